//--- thread_addressing.f
+incdir+include
src/thread_addr_pkg.sv
src/thread_counter.sv
src/offset_table.sv
src/operand_translator.sv
src/target_steer.sv
src/thread_addressing.sv
verif/thread_addressing_tb.sv

//--- Bender.yml
package:
  name: thread_addressing

sources:
  - include_dirs:
      - include
    files:
      - src/thread_addr_pkg.sv
      - src/thread_counter.sv
      - src/offset_table.sv
      - src/operand_translator.sv
      - src/target_steer.sv
      - src/thread_addressing.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/thread_addressing_tb.sv

//--- verif/thread_addressing_tb.sv
// Testbench for the thread addressing block
// Random operands and offset writes checked against a cycle model

`timescale 1ns/100ps
`default_nettype none

`include "thread_addr_defs.svh"

module thread_addressing_tb
    import thread_addr_pkg::*;
();

    localparam int CLK_PERIOD       = 4;
    localparam int DRIVE_DELAY      = 1;
    localparam int RESET_CYCLES     = 3;
    localparam int IDLE_CYCLES      = 4;
    localparam int ORDER_CYCLES     = 16;
    localparam int TRANSLATE_CYCLES = 64;
    localparam int SPECIAL_CYCLES   = 48;
    localparam int OUTSIDE_CYCLES   = 32;
    localparam int REWRITE_CYCLES   = 24;
    localparam int FULL_CYCLES      = 400;
    localparam int TOTAL_CYCLES     = RESET_CYCLES + 3 * IDLE_CYCLES + ORDER_CYCLES
                                      + `THREAD_COUNT + TRANSLATE_CYCLES + SPECIAL_CYCLES
                                      + OUTSIDE_CYCLES + 1 + REWRITE_CYCLES + FULL_CYCLES;
    localparam int MARGIN_NS        = 200;

    logic            clock;
    logic            rst_n;
    operand_t        operand;
    offset_write_t   offset_write;
    operand_result_t result;

    integer seed = 95;
    int     error_count = 0;
    int     check_count = 0;
    int     edge_count = 0;
    string  test_name = "reset";

    // Reference model state
    logic [`OFFSET_WIDTH-1:0] model_offsets [`THREAD_COUNT];
    int                       last_write_edge [`THREAD_COUNT];
    thread_t                  model_thread;
    operand_result_t          exp_q [$];
    string                    name_q [$];
    int                       pend_edge [$];
    thread_t                  pend_thread [$];
    logic [`OFFSET_WIDTH-1:0] pend_data [$];

    thread_addressing DUT (
        .clock        (clock),
        .rst_n        (rst_n),
        .operand      (operand),
        .offset_write (offset_write),
        .result       (result)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD + MARGIN_NS);
        $display("Timeout: run did not finish within %0d ns", TOTAL_CYCLES * CLK_PERIOD + MARGIN_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    // ============================================================
    // Model of the address map
    // ============================================================
    function automatic target_e target_of(input logic [`ADDR_WIDTH-1:0] a);
        if (a >= `HIGHMEM_BASE && a < `HIGHMEM_BASE + `HIGHMEM_COUNT) begin
            return TARGET_HIGHMEM;
        end else if (a >= `IO_A_BASE && a < `IO_A_BASE + `IO_PORT_COUNT) begin
            return TARGET_IO_A;
        end else if (a >= `IO_B_BASE && a < `IO_B_BASE + `IO_PORT_COUNT) begin
            return TARGET_IO_B;
        end
        return TARGET_MEM;
    endfunction

    function automatic operand_result_t expected_result(input operand_t op, input thread_t th);
        operand_result_t exp;
        exp = '0;
        exp.valid = op.valid;
        exp.thread = th;
        if (target_of(op.addr) == TARGET_MEM) begin
            exp.addr.mem = op.addr + model_offsets[th];
        end else begin
            exp.addr.mem = op.addr;
        end
        exp.target = target_of(exp.addr.mem);
        return exp;
    endfunction

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [`ADDR_WIDTH-1:0] plain_addr();
        logic [31:0] r;
        r = rand_word();
        while (target_of(r[`ADDR_WIDTH-1:0]) != TARGET_MEM) begin
            r = rand_word();
        end
        return r[`ADDR_WIDTH-1:0];
    endfunction

    function automatic logic [`ADDR_WIDTH-1:0] special_addr();
        logic [31:0] r;
        r = rand_word();
        case (r[31:8] % 3)
            0:       return `ADDR_WIDTH'(`HIGHMEM_BASE + r[7:2]);
            1:       return `ADDR_WIDTH'(`IO_A_BASE + r[4:2]);
            default: return `ADDR_WIDTH'(`IO_B_BASE + r[4:2]);
        endcase
    endfunction

    function automatic operand_t make_operand(input logic valid, input logic [`ADDR_WIDTH-1:0] a);
        operand_t op;
        op.valid = valid;
        op.addr = a;
        return op;
    endfunction

    function automatic offset_write_t window_write(input thread_t th);
        offset_write_t w;
        w.en = 1'b1;
        w.addr = `WRITE_ADDR_WIDTH'(`OFFSETS_BASE + th);
        w.data = `WORD_WIDTH'({rand_word(), rand_word()});
        return w;
    endfunction

    function automatic offset_write_t outside_write();
        offset_write_t w;
        logic [31:0]   r;
        r = rand_word();
        while (r[11:0] >= `OFFSETS_BASE && r[11:0] < `OFFSETS_BASE + `THREAD_COUNT) begin
            r = rand_word();
        end
        w.en = 1'b1;
        w.addr = r[`WRITE_ADDR_WIDTH-1:0];
        w.data = `WORD_WIDTH'({rand_word(), rand_word()});
        return w;
    endfunction

    // ============================================================
    // Compare tasks
    // ============================================================
    task automatic check_result(input string name, input operand_result_t exp,
                                input operand_result_t act);
        check_count++;
        if (!exp.valid && act.valid !== 1'b0) begin
            error_count++;
            $display("CHECK FAILED %s valid: expected 0 actual %b", name, act.valid);
        end else if (exp.valid && act !== exp) begin
            error_count++;
            $display("CHECK FAILED %s result: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_target(input string name, input target_e exp, input target_e act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED %s target: expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_index(input string name, input logic [`IO_INDEX_WIDTH-1:0] exp,
                               input logic [`IO_INDEX_WIDTH-1:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED %s io index: expected %0d actual %0d", name, exp, act);
        end
    endtask

    // One slot: drive, step the model, check the result three edges after its operand
    task automatic run_cycle(input operand_t op, input offset_write_t wr);
        operand_t        drive_op;
        operand_result_t exp;
        operand_result_t exp_old;
        string           name_old;
        drive_op = op;
        // Thread still inside its write settling window
        if (edge_count + 1 - last_write_edge[model_thread] < 3) begin
            drive_op.valid = 1'b0;
        end
        operand = drive_op;
        offset_write = wr;
        @(posedge clock);
        #DRIVE_DELAY;
        edge_count++;
        while (pend_edge.size() > 0 && pend_edge[0] <= edge_count) begin
            model_offsets[pend_thread[0]] = pend_data[0];
            void'(pend_edge.pop_front());
            void'(pend_thread.pop_front());
            void'(pend_data.pop_front());
        end
        exp = expected_result(operand, model_thread);
        model_thread = (model_thread == thread_t'(`THREAD_COUNT - 1)) ? '0 : model_thread + 1'b1;
        exp_q.push_back(exp);
        name_q.push_back(test_name);
        exp_old = exp_q.pop_front();
        name_old = name_q.pop_front();
        check_result(name_old, exp_old, result);
        if (exp_old.valid) begin
            check_target(name_old, exp_old.target, result.target);
            if (exp_old.target == TARGET_IO_A || exp_old.target == TARGET_IO_B) begin
                check_index(name_old, exp_old.addr.mem[`IO_INDEX_WIDTH-1:0], result.addr.io.index);
            end
        end
        if (offset_write.en && offset_write.addr >= `OFFSETS_BASE &&
            offset_write.addr < `OFFSETS_BASE + `THREAD_COUNT) begin
            pend_edge.push_back(edge_count + 3);
            pend_thread.push_back(offset_write.addr[`THREAD_WIDTH-1:0]);
            pend_data.push_back(offset_write.data[`OFFSET_WIDTH-1:0]);
            last_write_edge[offset_write.addr[`THREAD_WIDTH-1:0]] = edge_count;
        end
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        logic [31:0]   r;
        offset_write_t wr;
        operand = '0;
        offset_write = '0;
        rst_n = 1'b0;
        model_thread = '0;
        for (int i = 0; i < `THREAD_COUNT; i++) begin
            model_offsets[i] = '0;
            last_write_edge[i] = -100;
        end
        // Slots already in the pipe when reset lifts
        repeat (2) begin
            exp_q.push_back('0);
            name_q.push_back("reset");
        end
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        repeat (IDLE_CYCLES) run_cycle('0, '0);
        test_name = "thread_order";
        repeat (ORDER_CYCLES) run_cycle(make_operand(1'b1, plain_addr()), '0);

        test_name = "offset_translation";
        for (int th = 0; th < `THREAD_COUNT; th++) begin
            run_cycle('0, window_write(thread_t'(th)));
        end
        repeat (IDLE_CYCLES) run_cycle('0, '0);
        repeat (TRANSLATE_CYCLES) run_cycle(make_operand(1'b1, plain_addr()), '0);

        test_name = "untranslated_ranges";
        repeat (SPECIAL_CYCLES) run_cycle(make_operand(1'b1, special_addr()), '0);

        test_name = "write_outside_window";
        repeat (OUTSIDE_CYCLES) begin
            r = rand_word();
            run_cycle(make_operand(1'b1, r[`ADDR_WIDTH-1:0]), outside_write());
        end
        test_name = "rewrite_one_thread";
        run_cycle('0, window_write(thread_t'(5)));
        repeat (REWRITE_CYCLES) run_cycle(make_operand(1'b1, plain_addr()), '0);

        test_name = "full_rate";
        repeat (FULL_CYCLES) begin
            r = rand_word();
            if (r[1:0] == 2'd0) begin
                wr = window_write(thread_t'(r[7:5]));
            end else if (r[9:8] == 2'd0) begin
                wr = outside_write();
            end else begin
                wr = '0;
            end
            run_cycle(make_operand(r[31], r[`ADDR_WIDTH+9:10]), wr);
        end
        repeat (IDLE_CYCLES) run_cycle('0, '0);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/thread_addressing.sv
// Per-thread operand addressing for the barrel processor
// Thread offsets applied to private data, three cycles operand to result

`timescale 1ns/100ps
`default_nettype none

`include "thread_addr_defs.svh"

module thread_addressing
    import thread_addr_pkg::*;
(
    input  wire                  clock,
    input  wire                  rst_n,
    input  wire operand_t        operand,
    input  wire offset_write_t   offset_write,
    output operand_result_t      result
);

    thread_t                  current_thread;
    thread_t                  next_thread;
    logic [`OFFSET_WIDTH-1:0] offset;
    operand_result_t          xlat_operand;

    // ============================================================
    // Thread sequencing and offsets
    // ============================================================
    thread_counter u_thread_counter (
        .clock          (clock),
        .rst_n          (rst_n),
        .current_thread (current_thread),
        .next_thread    (next_thread)
    );

    offset_table u_offset_table (
        .clock          (clock),
        .rst_n          (rst_n),
        .offset_write   (offset_write),
        .next_thread    (next_thread),
        .offset         (offset)
    );

    // ============================================================
    // Translation and steering
    // ============================================================
    operand_translator u_operand_translator (
        .clock          (clock),
        .rst_n          (rst_n),
        .operand        (operand),
        .current_thread (current_thread),
        .offset         (offset),
        .xlat_operand   (xlat_operand)
    );

    target_steer u_target_steer (
        .clock          (clock),
        .rst_n          (rst_n),
        .xlat_operand   (xlat_operand),
        .result         (result)
    );

endmodule

`default_nettype wire

//--- src/target_steer.sv
// Target classification of the final operand address
// Registers the result with its memory or I/O port class

`timescale 1ns/100ps
`default_nettype none

`include "thread_addr_defs.svh"

module target_steer
    import thread_addr_pkg::*;
(
    input  wire                  clock,
    input  wire                  rst_n,
    input  wire operand_result_t xlat_operand,
    output operand_result_t      result
);

    localparam int BASE_WIDTH = `ADDR_WIDTH - `IO_INDEX_WIDTH;
    localparam logic [BASE_WIDTH-1:0] IO_A_FIELD = BASE_WIDTH'(`IO_A_BASE >> `IO_INDEX_WIDTH);
    localparam logic [BASE_WIDTH-1:0] IO_B_FIELD = BASE_WIDTH'(`IO_B_BASE >> `IO_INDEX_WIDTH);

    // Classed by where the final address lands
    target_e target;

    always_comb begin
        if (addr_in_range(32'(xlat_operand.addr.mem), `HIGHMEM_BASE, `HIGHMEM_COUNT)) begin
            target = TARGET_HIGHMEM;
        end else if (xlat_operand.addr.io.base == IO_A_FIELD) begin
            target = TARGET_IO_A;
        end else if (xlat_operand.addr.io.base == IO_B_FIELD) begin
            target = TARGET_IO_B;
        end else begin
            target = TARGET_MEM;
        end
    end

    // ============================================================
    // Output register
    // ============================================================
    logic       res_valid;
    thread_t    res_thread;
    target_e    res_target;
    addr_view_u res_addr;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= xlat_operand.valid;
        end
    end

    always_ff @(posedge clock) begin
        res_thread <= xlat_operand.thread;
        res_target <= target;
        res_addr   <= xlat_operand.addr;
    end

    always_comb begin
        result.valid  = res_valid;
        result.thread = res_thread;
        result.target = res_target;
        result.addr   = res_addr;
    end

endmodule

`default_nettype wire

//--- src/operand_translator.sv
// Operand address translation
// Adds the thread offset unless the operand hits High-Mem or an I/O range

`timescale 1ns/100ps
`default_nettype none

`include "thread_addr_defs.svh"

module operand_translator
    import thread_addr_pkg::*;
(
    input  wire                       clock,
    input  wire                       rst_n,
    input  wire operand_t             operand,
    input  wire thread_t              current_thread,
    input  wire [`OFFSET_WIDTH-1:0]   offset,
    output operand_result_t           xlat_operand
);

    // ============================================================
    // Range decode on the raw address
    // ============================================================
    logic in_highmem;
    logic in_io_a;
    logic in_io_b;

    assign in_highmem = addr_in_range(32'(operand.addr), `HIGHMEM_BASE, `HIGHMEM_COUNT);
    assign in_io_a    = addr_in_range(32'(operand.addr), `IO_A_BASE, `IO_PORT_COUNT);
    assign in_io_b    = addr_in_range(32'(operand.addr), `IO_B_BASE, `IO_PORT_COUNT);

    // ============================================================
    // Stage 1: raw and offset addresses side by side
    // ============================================================
    logic                   s1_valid;
    thread_t                s1_thread;
    logic                   s1_use_raw;
    logic [`ADDR_WIDTH-1:0] s1_raw_addr;
    logic [`ADDR_WIDTH-1:0] s1_offset_addr;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= operand.valid;
        end
    end

    always_ff @(posedge clock) begin
        s1_thread      <= current_thread;
        s1_raw_addr    <= operand.addr;
        // Wraps modulo the address space
        s1_offset_addr <= operand.addr + offset;
        // Ranges are disjoint
        s1_use_raw     <= in_highmem | in_io_a | in_io_b;
    end

    // ============================================================
    // Stage 2: address select
    // ============================================================
    logic                   s2_valid;
    thread_t                s2_thread;
    logic [`ADDR_WIDTH-1:0] s2_addr;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        s2_thread <= s1_thread;
        s2_addr   <= s1_use_raw ? s1_raw_addr : s1_offset_addr;
    end

    // Target is classified downstream
    always_comb begin
        xlat_operand.valid    = s2_valid;
        xlat_operand.thread   = s2_thread;
        xlat_operand.target   = TARGET_MEM;
        xlat_operand.addr.mem = s2_addr;
    end

endmodule

`default_nettype wire

//--- src/offset_table.sv
// Per-thread base offset storage
// Decodes writes to the offset window and reads ahead for the next thread

`timescale 1ns/100ps
`default_nettype none

`include "thread_addr_defs.svh"

module offset_table
    import thread_addr_pkg::*;
(
    input  wire                       clock,
    input  wire                       rst_n,
    input  wire offset_write_t        offset_write,
    input  wire thread_t              next_thread,
    output logic [`OFFSET_WIDTH-1:0]  offset
);

    localparam int DELAY = `OFFSETS_WRITE_DELAY;
    localparam int LAST  = DELAY - 1;

    // ============================================================
    // Write alignment
    // ============================================================
    logic [DELAY-1:0]              wr_en_pipe;
    logic [`WRITE_ADDR_WIDTH-1:0]  wr_addr_pipe [DELAY];
    logic [`OFFSET_WIDTH-1:0]      wr_data_pipe [DELAY];
    logic                          wr_hit;
    thread_t                       wr_thread;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_en_pipe <= '0;
        end else begin
            wr_en_pipe[0] <= offset_write.en;
            for (int i = 1; i < DELAY; i++) begin
                wr_en_pipe[i] <= wr_en_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        wr_addr_pipe[0] <= offset_write.addr;
        wr_data_pipe[0] <= offset_write.data[`OFFSET_WIDTH-1:0];
        for (int i = 1; i < DELAY; i++) begin
            wr_addr_pipe[i] <= wr_addr_pipe[i-1];
            wr_data_pipe[i] <= wr_data_pipe[i-1];
        end
    end

    // Only the offset window, one entry per thread
    assign wr_hit = wr_en_pipe[LAST] &&
                    addr_in_range(32'(wr_addr_pipe[LAST]), `OFFSETS_BASE, `THREAD_COUNT);
    assign wr_thread = wr_addr_pipe[LAST][`THREAD_WIDTH-1:0];

    // ============================================================
    // Offset storage
    // ============================================================
    logic [`OFFSET_WIDTH-1:0] offsets [`THREAD_COUNT];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `THREAD_COUNT; i++) begin
                offsets[i] <= '0;
            end
        end else if (wr_hit) begin
            offsets[wr_thread] <= wr_data_pipe[LAST];
        end
    end

    // Read one cycle ahead, lands with the current thread's operand
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            offset <= '0;
        end else begin
            offset <= offsets[next_thread];
        end
    end

endmodule

`default_nettype wire

//--- src/thread_counter.sv
// Round-robin thread counter for the barrel pipeline
// Also gives the following thread so table reads can start a cycle early

`timescale 1ns/100ps
`default_nettype none

`include "thread_addr_defs.svh"

module thread_counter
    import thread_addr_pkg::*;
(
    input  wire     clock,
    input  wire     rst_n,
    output thread_t current_thread,
    output thread_t next_thread
);

    // Wrap at the last thread
    always_comb begin
        if (current_thread == thread_t'(`THREAD_COUNT - 1)) begin
            next_thread = '0;
        end else begin
            next_thread = current_thread + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            current_thread <= '0;
        end else begin
            current_thread <= next_thread;
        end
    end

endmodule

`default_nettype wire

//--- src/thread_addr_pkg.sv
// Shared types for the thread addressing subsystem
// Operands, offset writes, results and the two-way address view

`default_nettype none

`include "thread_addr_defs.svh"

package thread_addr_pkg;

    typedef logic [`THREAD_WIDTH-1:0] thread_t;

    typedef struct packed {
        logic                   valid;
        logic [`ADDR_WIDTH-1:0] addr;
    } operand_t;

    typedef struct packed {
        logic                         en;
        logic [`WRITE_ADDR_WIDTH-1:0] addr;
        logic [`WORD_WIDTH-1:0]       data;
    } offset_write_t;

    typedef enum logic [1:0] {
        TARGET_MEM,
        TARGET_HIGHMEM,
        TARGET_IO_A,
        TARGET_IO_B
    } target_e;

    // I/O port ranges are aligned, so the upper bits pick the port
    typedef struct packed {
        logic [`ADDR_WIDTH-`IO_INDEX_WIDTH-1:0] base;
        logic [`IO_INDEX_WIDTH-1:0]             index;
    } io_addr_t;

    typedef union packed {
        logic [`ADDR_WIDTH-1:0] mem;
        io_addr_t               io;
    } addr_view_u;

    typedef struct packed {
        logic       valid;
        thread_t    thread;
        target_e    target;
        addr_view_u addr;
    } operand_result_t;

    // Half-open range check on a zero-extended address
    function automatic logic addr_in_range(input logic [31:0] addr,
                                           input logic [31:0] base,
                                           input logic [31:0] count);
        return (addr >= base) && (addr < base + count);
    endfunction

endpackage

`default_nettype wire

//--- include/thread_addr_defs.svh
// Thread addressing subsystem constants
// Widths, thread count and the operand/write address map

`ifndef THREAD_ADDR_DEFS_SVH
`define THREAD_ADDR_DEFS_SVH

// ============================================================
// Datapath widths
// ============================================================
`define ADDR_WIDTH          10
`define WRITE_ADDR_WIDTH    12
`define WORD_WIDTH          36

// ============================================================
// Threads and offsets
// ============================================================
`define THREAD_COUNT        8
`define THREAD_WIDTH        3
`define OFFSET_WIDTH        10
`define OFFSETS_BASE        'h400
`define OFFSETS_WRITE_DELAY 1

// ============================================================
// Operand address map
// ============================================================
`define HIGHMEM_BASE        'h380
`define HIGHMEM_COUNT       64
`define IO_A_BASE           'h3F0
`define IO_B_BASE           'h3F8
`define IO_PORT_COUNT       8
`define IO_INDEX_WIDTH      3

`endif
